// File: sim.f
cpu6_pkg.sv
cpu6_instr_match.sv
cpu6_control_table.sv
cpu6_maindec.sv
cpu6_maindec_checker.sv
tb_clock.sv
tb_maindec.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f sim.f --top-module tb_maindec -o sim_maindec || exit 1
out=$(./obj_dir/sim_maindec 2>&1)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1

// File: tb_maindec.sv
`timescale 1ns/1ns

module tb_maindec;

   localparam int NUM_INSTR      = 2000;
   localparam int RESET_CYCLES   = 4;
   localparam int TIMEOUT_CYCLES = NUM_INSTR + RESET_CYCLES + 100;

   logic                    clk;
   logic                    rst_n;
   cpu6_pkg::rv32_instr_t   instr;
   logic                    instr_valid;
   cpu6_pkg::maindec_ctrl_t ctrl;
   logic                    illinstr;
   logic                    ctrl_valid;

   logic [31:0]             rng_state;   // xorshift state
   logic [31:0]             raw;         // random fields
   logic [31:0]             sel;         // random choices
   cpu6_pkg::rv32_instr_t   new_instr;
   logic                    new_valid;
   cpu6_pkg::maindec_ctrl_t exp_ctrl;    // prediction for the word now visible
   logic                    exp_ill;
   logic                    exp_valid;
   cpu6_pkg::maindec_ctrl_t next_ctrl;   // prediction for the word just driven
   logic                    next_ill;
   int                      cycles;

   tb_clock i_clock (.clk(clk), .rst_n(rst_n));

   cpu6_maindec i_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr       (instr),
      .instr_valid (instr_valid),
      .ctrl        (ctrl),
      .illinstr    (illinstr),
      .ctrl_valid  (ctrl_valid)
   );

   function automatic logic [31:0] next_random(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // supported kind, near miss or raw word, register fields always random
   function automatic cpu6_pkg::rv32_instr_t build_instr(input logic [31:0] s,
                                                         input logic [31:0] r);
      cpu6_pkg::rv32_instr_t w;
      int                    idx;
      w   = r;
      idx = int'(s[15:8]) % 20;
      if (s[2:0] == 3'd1) begin
         case (int'(s[7:3]) % 5)
            0: begin
               w.opcode = cpu6_pkg::OP_REG;
               w.funct7 = 7'd32;
               w.funct3 = 3'd7;
            end
            1: begin
               w.opcode = cpu6_pkg::OP_SYSTEM;
               w.funct3 = 3'd4;
            end
            2: begin
               w.opcode = cpu6_pkg::OP_JALR;
               w.funct3 = 3'd1;
            end
            3: begin
               w.opcode = cpu6_pkg::OP_BRANCH;
               w.funct3 = 3'd4;
            end
            default: begin
               w.opcode = cpu6_pkg::OP_SYSTEM;  // ecall-like, not mret
               w.funct3 = 3'd0;
               w.funct7 = 7'd0;
            end
         endcase
      end else if (s[2:0] != 3'd0) begin
         case (idx)
            0: w.opcode = cpu6_pkg::OP_LOAD;
            1: w.opcode = cpu6_pkg::OP_STORE;
            2, 3, 4: begin
               w.opcode = cpu6_pkg::OP_IMM;
               w.funct3 = (idx == 2) ? 3'd0 : (idx == 3) ? 3'd7 : 3'd6;  // addi andi ori
            end
            5, 6, 7: begin
               w.opcode = cpu6_pkg::OP_REG;
               w.funct3 = (idx == 7) ? 3'd7 : 3'd0;
               w.funct7 = (idx == 6) ? 7'd32 : 7'd0;  // sub only
            end
            8, 9: begin
               w.opcode = cpu6_pkg::OP_BRANCH;
               w.funct3 = 3'(idx - 8);
            end
            10: begin
               w.opcode = cpu6_pkg::OP_JALR;
               w.funct3 = 3'd0;
            end
            11, 12, 13: begin
               w.opcode = cpu6_pkg::OP_SYSTEM;
               w.funct3 = 3'(idx - 10);
            end
            14, 15, 16: begin
               w.opcode = cpu6_pkg::OP_SYSTEM;
               w.funct3 = 3'(idx - 9);
            end
            17: begin
               w.opcode = cpu6_pkg::OP_SYSTEM;
               w.funct3 = 3'd0;
               w.funct7 = 7'd24;
            end
            18: w.opcode = cpu6_pkg::OP_LUI;
            default: w.opcode = cpu6_pkg::OP_AUIPC;
         endcase
      end  // mode 0 keeps the raw word
      return w;
   endfunction

   // reference decode straight from the isa fields
   function automatic cpu6_pkg::maindec_ctrl_t expect_word(input cpu6_pkg::rv32_instr_t in,
                                                           output logic ill);
      cpu6_pkg::maindec_ctrl_t c;
      c   = cpu6_pkg::CTRL_BUBBLE;
      ill = 1'b0;
      case (in.opcode)
         cpu6_pkg::OP_LOAD: begin
            c.memtoreg = 1'b1;
            c.regwrite = 1'b1;
            c.alusrc   = cpu6_pkg::ALUSRC_IMM;
            c.immtype  = cpu6_pkg::IMM_I;
         end
         cpu6_pkg::OP_STORE: begin
            c.memwrite = 1'b1;
            c.alusrc   = cpu6_pkg::ALUSRC_IMM;
            c.immtype  = cpu6_pkg::IMM_S;
         end
         cpu6_pkg::OP_IMM: begin
            ill = !(in.funct3 == 3'd0 || in.funct3 == 3'd6 || in.funct3 == 3'd7);
            c.regwrite = 1'b1;
            c.alusrc   = cpu6_pkg::ALUSRC_IMM;
            c.aluop    = cpu6_pkg::ALUOP_ARITH;
            c.immtype  = cpu6_pkg::IMM_I;
         end
         cpu6_pkg::OP_REG: begin
            ill = !({in.funct7, in.funct3} == 10'h000 || {in.funct7, in.funct3} == 10'h100 ||
                    {in.funct7, in.funct3} == 10'h007);  // add, sub, and
            c.regwrite = 1'b1;
            c.aluop    = cpu6_pkg::ALUOP_ARITH;
         end
         cpu6_pkg::OP_BRANCH: begin
            ill          = in.funct3 > 3'd1;
            c.branchtype = (in.funct3 == 3'd0) ? cpu6_pkg::BR_BEQ : cpu6_pkg::BR_BNE;
            c.aluop      = cpu6_pkg::ALUOP_BRANCH;
            c.immtype    = cpu6_pkg::IMM_B;
         end
         cpu6_pkg::OP_JALR: begin
            ill        = in.funct3 != 3'd0;
            c.regwrite = 1'b1;
            c.jump     = 1'b1;
            c.alusrc   = cpu6_pkg::ALUSRC_IMM;
            c.immtype  = cpu6_pkg::IMM_I;
         end
         cpu6_pkg::OP_SYSTEM: begin
            c.alusrc  = cpu6_pkg::ALUSRC_IMM;
            c.immtype = cpu6_pkg::IMM_I;
            if (in.funct3 == 3'd0) begin
               ill    = in.funct7 != 7'd24;
               c.mret = 1'b1;
            end else begin
               ill        = in.funct3[1:0] == 2'd0;  // funct3 4
               c.csr      = 1'b1;
               c.regwrite = 1'b1;
               c.csr_uimm = in.funct3[2];  // immediate forms
               c.csr_wsc  = cpu6_pkg::csr_wsc_e'(in.funct3[1:0]);
            end
         end
         cpu6_pkg::OP_LUI, cpu6_pkg::OP_AUIPC: begin
            c.lui      = in.opcode == cpu6_pkg::OP_LUI;
            c.auipc    = in.opcode == cpu6_pkg::OP_AUIPC;
            c.regwrite = 1'b1;
            c.alusrc   = cpu6_pkg::ALUSRC_IMM;
            c.immtype  = cpu6_pkg::IMM_U;
         end
         default: ill = 1'b1;
      endcase
      if (ill) begin
         c = cpu6_pkg::CTRL_BUBBLE;  // illegal slot is a bubble
      end
      return c;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_outputs();
      compare_value("ctrl", 32'(ctrl), 32'(exp_ctrl));
      compare_value("illinstr", 32'(illinstr), 32'(exp_ill));
      compare_value("ctrl_valid", 32'(ctrl_valid), 32'(exp_valid));
   endtask

   // hang guard
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: decoder run still going after %0d cycles", cycles);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   end

   initial begin
      instr       = '0;
      instr_valid = 1'b0;
      cycles      = 0;
      rng_state   = 32'd21;  // fixed seed
      exp_ctrl    = cpu6_pkg::CTRL_BUBBLE;
      exp_ill     = 1'b0;
      exp_valid   = 1'b0;
      @(posedge rst_n);
      @(negedge clk);
      check_outputs();  // reset state
      for (int n = 0; n <= NUM_INSTR; n++) begin
         @(posedge clk);
         rng_state = next_random(rng_state);
         raw       = rng_state;
         rng_state = next_random(rng_state);
         sel       = rng_state;
         new_instr = build_instr(sel, raw);
         new_valid = (n < NUM_INSTR) && (int'(sel[31:24]) % 5 != 0);  // last slot flushes
         instr       <= new_instr;
         instr_valid <= new_valid;
         next_ctrl = expect_word(new_instr, next_ill);
         if (!new_valid) begin
            next_ctrl = cpu6_pkg::CTRL_BUBBLE;
            next_ill  = 1'b0;
         end
         @(negedge clk);
         check_outputs();  // word driven one edge earlier
         exp_ctrl  = next_ctrl;
         exp_ill   = next_ill;
         exp_valid = new_valid;
      end
      @(posedge clk);
      @(negedge clk);
      check_outputs();  // flush slot
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// File: tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;  // 10 ns period
   end

   initial begin
      rst_n = 1'b0;
      repeat (4) @(posedge clk);  // reset held for 4 cycles
      rst_n <= 1'b1;  // released on an edge, sync reset
   end

endmodule

// File: cpu6_maindec_checker.sv
`timescale 1ns/1ns

module cpu6_maindec_checker (
   input logic                    clk,
   input logic                    rst_n,
   input cpu6_pkg::maindec_ctrl_t ctrl,
   input logic                    illinstr,
   input logic                    ctrl_valid
);

   // an illegal encoding must leave no side effects
   a_illegal_is_bubble: assert property (@(posedge clk) disable iff (!rst_n)
      illinstr |-> ctrl == cpu6_pkg::CTRL_BUBBLE)
      else $error("illinstr high with a control word other than the bubble");

   // idle slots carry the bubble
   a_idle_is_bubble: assert property (@(posedge clk) disable iff (!rst_n)
      !ctrl_valid |-> ctrl == cpu6_pkg::CTRL_BUBBLE)
      else $error("ctrl_valid low with a control word other than the bubble");

   a_no_reg_and_mem_write: assert property (@(posedge clk) disable iff (!rst_n)
      !(ctrl.regwrite && ctrl.memwrite))
      else $error("regwrite and memwrite high in the same control word");

endmodule

bind cpu6_maindec cpu6_maindec_checker i_checker (
   .clk        (clk),
   .rst_n      (rst_n),
   .ctrl       (ctrl),
   .illinstr   (illinstr),
   .ctrl_valid (ctrl_valid)
);

// File: cpu6_maindec.sv
`timescale 1ns/1ns

// main decode stage: field match, then the registered control word
module cpu6_maindec (
   input  logic                    clk,
   input  logic                    rst_n,
   input  cpu6_pkg::rv32_instr_t   instr,
   input  logic                    instr_valid,
   output cpu6_pkg::maindec_ctrl_t ctrl,
   output logic                    illinstr,
   output logic                    ctrl_valid
);

   cpu6_pkg::instr_kind_e kind;  // combinational, same cycle as instr

   // rd, rs1 and rs2 are not needed here
   cpu6_instr_match i_match (
      .opcode (instr.opcode),
      .funct3 (instr.funct3),
      .funct7 (instr.funct7),
      .kind   (kind)
   );

   cpu6_control_table i_table (
      .clk         (clk),
      .rst_n       (rst_n),
      .kind        (kind),
      .instr_valid (instr_valid),
      .ctrl        (ctrl),        // one cycle after capture
      .illinstr    (illinstr),
      .ctrl_valid  (ctrl_valid)
   );

endmodule

// File: cpu6_control_table.sv
`timescale 1ns/1ns

module cpu6_control_table (
   input  logic                   clk,
   input  logic                   rst_n,
   input  cpu6_pkg::instr_kind_e  kind,
   input  logic                   instr_valid,
   output cpu6_pkg::maindec_ctrl_t ctrl,
   output logic                   illinstr,
   output logic                   ctrl_valid
);

   cpu6_pkg::maindec_ctrl_t ctrl_d;     // decoded word before the register
   logic                    illegal_d;  // kind not supported

   // start from the bubble, set only what the kind needs
   always_comb begin
      ctrl_d    = cpu6_pkg::CTRL_BUBBLE;
      illegal_d = 1'b0;
      case (kind)
         cpu6_pkg::INSTR_LW: begin
            ctrl_d.memtoreg = 1'b1;
            ctrl_d.regwrite = 1'b1;
            ctrl_d.alusrc   = cpu6_pkg::ALUSRC_IMM;
            ctrl_d.aluop    = cpu6_pkg::ALUOP_LWSWJALR;  // base + offset
            ctrl_d.immtype  = cpu6_pkg::IMM_I;
         end
         cpu6_pkg::INSTR_SW: begin
            ctrl_d.memwrite = 1'b1;
            ctrl_d.alusrc   = cpu6_pkg::ALUSRC_IMM;
            ctrl_d.aluop    = cpu6_pkg::ALUOP_LWSWJALR;
            ctrl_d.immtype  = cpu6_pkg::IMM_S;  // split immediate
         end
         cpu6_pkg::INSTR_ADDI, cpu6_pkg::INSTR_ANDI, cpu6_pkg::INSTR_ORI: begin
            ctrl_d.regwrite = 1'b1;
            ctrl_d.alusrc   = cpu6_pkg::ALUSRC_IMM;
            ctrl_d.aluop    = cpu6_pkg::ALUOP_ARITH;  // alu decoder uses funct3
            ctrl_d.immtype  = cpu6_pkg::IMM_I;
         end
         cpu6_pkg::INSTR_ADD, cpu6_pkg::INSTR_SUB, cpu6_pkg::INSTR_AND: begin
            ctrl_d.regwrite = 1'b1;
            ctrl_d.alusrc   = cpu6_pkg::ALUSRC_RS2;
            ctrl_d.aluop    = cpu6_pkg::ALUOP_ARITH;
            ctrl_d.immtype  = cpu6_pkg::IMM_R;  // no imm
         end
         cpu6_pkg::INSTR_BEQ, cpu6_pkg::INSTR_BNE: begin
            ctrl_d.branchtype = (kind == cpu6_pkg::INSTR_BEQ) ? cpu6_pkg::BR_BEQ
                                                              : cpu6_pkg::BR_BNE;
            ctrl_d.alusrc     = cpu6_pkg::ALUSRC_RS2;  // rs1 vs rs2
            ctrl_d.aluop      = cpu6_pkg::ALUOP_BRANCH;
            ctrl_d.immtype    = cpu6_pkg::IMM_B;
         end
         cpu6_pkg::INSTR_JALR: begin
            ctrl_d.regwrite = 1'b1;  // link address
            ctrl_d.jump     = 1'b1;
            ctrl_d.alusrc   = cpu6_pkg::ALUSRC_IMM;
            ctrl_d.aluop    = cpu6_pkg::ALUOP_LWSWJALR;  // target = rs1 + imm
            ctrl_d.immtype  = cpu6_pkg::IMM_I;
         end
         cpu6_pkg::INSTR_CSRRW, cpu6_pkg::INSTR_CSRRS, cpu6_pkg::INSTR_CSRRC,
         cpu6_pkg::INSTR_CSRRWI, cpu6_pkg::INSTR_CSRRSI, cpu6_pkg::INSTR_CSRRCI: begin
            ctrl_d.csr      = 1'b1;
            ctrl_d.regwrite = 1'b1;  // old csr value to rd
            ctrl_d.alusrc   = cpu6_pkg::ALUSRC_IMM;
            ctrl_d.immtype  = cpu6_pkg::IMM_I;  // csr address in imm12
            ctrl_d.csr_uimm = kind inside {cpu6_pkg::INSTR_CSRRWI, cpu6_pkg::INSTR_CSRRSI,
                                           cpu6_pkg::INSTR_CSRRCI};
            if (kind == cpu6_pkg::INSTR_CSRRW || kind == cpu6_pkg::INSTR_CSRRWI) begin
               ctrl_d.csr_wsc = cpu6_pkg::CSR_W;
            end else if (kind == cpu6_pkg::INSTR_CSRRS || kind == cpu6_pkg::INSTR_CSRRSI) begin
               ctrl_d.csr_wsc = cpu6_pkg::CSR_S;
            end else begin
               ctrl_d.csr_wsc = cpu6_pkg::CSR_C;
            end
         end
         cpu6_pkg::INSTR_MRET: begin
            ctrl_d.mret    = 1'b1;  // pc from mepc, nothing written
            ctrl_d.alusrc  = cpu6_pkg::ALUSRC_IMM;
            ctrl_d.immtype = cpu6_pkg::IMM_I;
         end
         cpu6_pkg::INSTR_LUI, cpu6_pkg::INSTR_AUIPC: begin
            ctrl_d.lui      = (kind == cpu6_pkg::INSTR_LUI);
            ctrl_d.auipc    = (kind == cpu6_pkg::INSTR_AUIPC);
            ctrl_d.regwrite = 1'b1;
            ctrl_d.alusrc   = cpu6_pkg::ALUSRC_IMM;
            ctrl_d.aluop    = cpu6_pkg::ALUOP_LWSWJALR;
            ctrl_d.immtype  = cpu6_pkg::IMM_U;  // upper 20 bits
         end
         default: begin
            illegal_d = 1'b1;  // word stays the bubble
         end
      endcase
   end

   // decode pipeline register, idle cycles load the bubble
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ctrl       <= cpu6_pkg::CTRL_BUBBLE;
         illinstr   <= 1'b0;
         ctrl_valid <= 1'b0;
      end else begin
         ctrl       <= instr_valid ? ctrl_d : cpu6_pkg::CTRL_BUBBLE;
         illinstr   <= instr_valid & illegal_d;  // only flagged for a real fetch
         ctrl_valid <= instr_valid;
      end
   end

endmodule

// File: cpu6_instr_match.sv
`timescale 1ns/1ns

module cpu6_instr_match (
   input  cpu6_pkg::opcode_t     opcode,
   input  cpu6_pkg::funct3_t     funct3,
   input  cpu6_pkg::funct7_t     funct7,
   output cpu6_pkg::instr_kind_e kind
);

   always_comb begin
      kind = cpu6_pkg::INSTR_ILLEGAL;  // anything unmatched
      case (opcode)
         cpu6_pkg::OP_LOAD:  kind = cpu6_pkg::INSTR_LW;  // funct3 not checked
         cpu6_pkg::OP_STORE: kind = cpu6_pkg::INSTR_SW;  // funct3 not checked
         cpu6_pkg::OP_LUI:   kind = cpu6_pkg::INSTR_LUI;
         cpu6_pkg::OP_AUIPC: kind = cpu6_pkg::INSTR_AUIPC;
         cpu6_pkg::OP_IMM: begin
            case (funct3)  // funct7 ignored for immediates
               cpu6_pkg::F3_ADDI: kind = cpu6_pkg::INSTR_ADDI;
               cpu6_pkg::F3_ORI:  kind = cpu6_pkg::INSTR_ORI;
               cpu6_pkg::F3_ANDI: kind = cpu6_pkg::INSTR_ANDI;
               default:           kind = cpu6_pkg::INSTR_ILLEGAL;  // shifts, slti, xori
            endcase
         end
         cpu6_pkg::OP_REG: begin
            if (funct3 == cpu6_pkg::F3_ADD && funct7 == cpu6_pkg::F7_BASE) begin
               kind = cpu6_pkg::INSTR_ADD;
            end else if (funct3 == cpu6_pkg::F3_ADD && funct7 == cpu6_pkg::F7_ALT) begin
               kind = cpu6_pkg::INSTR_SUB;
            end else if (funct3 == cpu6_pkg::F3_AND && funct7 == cpu6_pkg::F7_BASE) begin
               kind = cpu6_pkg::INSTR_AND;
            end  // or, xor, slt, shifts stay illegal
         end
         cpu6_pkg::OP_BRANCH: begin
            case (funct3)
               cpu6_pkg::F3_BEQ: kind = cpu6_pkg::INSTR_BEQ;
               cpu6_pkg::F3_BNE: kind = cpu6_pkg::INSTR_BNE;
               default:          kind = cpu6_pkg::INSTR_ILLEGAL;  // blt, bge and friends
            endcase
         end
         cpu6_pkg::OP_JALR: begin
            if (funct3 == cpu6_pkg::F3_JALR) begin
               kind = cpu6_pkg::INSTR_JALR;
            end
         end
         cpu6_pkg::OP_SYSTEM: begin
            // funct3 picks the csr flavour, 0 is the privileged group
            case (funct3)
               cpu6_pkg::F3_PRIV: begin
                  if (funct7 == cpu6_pkg::F7_MRET) begin
                     kind = cpu6_pkg::INSTR_MRET;  // ecall/ebreak not supported
                  end
               end
               cpu6_pkg::F3_CSRRW:  kind = cpu6_pkg::INSTR_CSRRW;
               cpu6_pkg::F3_CSRRS:  kind = cpu6_pkg::INSTR_CSRRS;
               cpu6_pkg::F3_CSRRC:  kind = cpu6_pkg::INSTR_CSRRC;
               cpu6_pkg::F3_CSRRWI: kind = cpu6_pkg::INSTR_CSRRWI;
               cpu6_pkg::F3_CSRRSI: kind = cpu6_pkg::INSTR_CSRRSI;
               cpu6_pkg::F3_CSRRCI: kind = cpu6_pkg::INSTR_CSRRCI;
               default:             kind = cpu6_pkg::INSTR_ILLEGAL;  // funct3 = 4
            endcase
         end
         default: kind = cpu6_pkg::INSTR_ILLEGAL;  // jal, fence, custom
      endcase
   end

endmodule

// File: cpu6_pkg.sv
package cpu6_pkg;

   // isa field widths
   localparam int OPCODE_W  = 7;
   localparam int FUNCT3_W  = 3;
   localparam int FUNCT7_W  = 7;
   localparam int REG_IDX_W = 5;

   typedef logic [OPCODE_W-1:0]  opcode_t;
   typedef logic [FUNCT3_W-1:0]  funct3_t;
   typedef logic [FUNCT7_W-1:0]  funct7_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // base rv32 instruction layout, msb first
   typedef struct packed {
      funct7_t  funct7;  // [31:25]
      reg_idx_t rs2;     // [24:20]
      reg_idx_t rs1;     // [19:15]
      funct3_t  funct3;  // [14:12]
      reg_idx_t rd;      // [11:7]
      opcode_t  opcode;  // [6:0]
   } rv32_instr_t;

   // major opcodes
   localparam opcode_t OP_LOAD   = 7'b0000011;
   localparam opcode_t OP_STORE  = 7'b0100011;
   localparam opcode_t OP_IMM    = 7'b0010011;
   localparam opcode_t OP_REG    = 7'b0110011;
   localparam opcode_t OP_BRANCH = 7'b1100011;
   localparam opcode_t OP_JALR   = 7'b1100111;
   localparam opcode_t OP_SYSTEM = 7'b1110011;
   localparam opcode_t OP_LUI    = 7'b0110111;
   localparam opcode_t OP_AUIPC  = 7'b0010111;

   // funct3 selectors
   localparam funct3_t F3_ADD    = 3'd0;  // add and sub share it
   localparam funct3_t F3_AND    = 3'd7;
   localparam funct3_t F3_ADDI   = 3'd0;
   localparam funct3_t F3_ORI    = 3'd6;
   localparam funct3_t F3_ANDI   = 3'd7;
   localparam funct3_t F3_BEQ    = 3'd0;
   localparam funct3_t F3_BNE    = 3'd1;
   localparam funct3_t F3_JALR   = 3'd0;
   localparam funct3_t F3_PRIV   = 3'd0;  // mret lives here
   localparam funct3_t F3_CSRRW  = 3'd1;
   localparam funct3_t F3_CSRRS  = 3'd2;
   localparam funct3_t F3_CSRRC  = 3'd3;
   localparam funct3_t F3_CSRRWI = 3'd5;
   localparam funct3_t F3_CSRRSI = 3'd6;
   localparam funct3_t F3_CSRRCI = 3'd7;

   // funct7 selectors
   localparam funct7_t F7_BASE = 7'd0;
   localparam funct7_t F7_ALT  = 7'd32;  // sub
   localparam funct7_t F7_MRET = 7'd24;  // 0011000

   // supported instructions, one code each
   typedef enum logic [4:0] {
      INSTR_ILLEGAL = 5'd0,
      INSTR_LW,
      INSTR_SW,
      INSTR_ADDI,
      INSTR_ANDI,
      INSTR_ORI,
      INSTR_ADD,
      INSTR_SUB,
      INSTR_AND,
      INSTR_BEQ,
      INSTR_BNE,
      INSTR_JALR,
      INSTR_CSRRW,
      INSTR_CSRRS,
      INSTR_CSRRC,
      INSTR_CSRRWI,
      INSTR_CSRRSI,
      INSTR_CSRRCI,
      INSTR_MRET,
      INSTR_LUI,
      INSTR_AUIPC
   } instr_kind_e;

   typedef enum logic [2:0] {
      BR_BEQ  = 3'd0,
      BR_BNE  = 3'd1,
      BR_NONE = 3'd2  // nonzero, bubble must set it
   } branch_type_e;

   typedef enum logic [1:0] {
      ALUOP_LWSWJALR = 2'd0,  // address add
      ALUOP_BRANCH   = 2'd1,  // compare
      ALUOP_ARITH    = 2'd2   // funct3/funct7 decide
   } alu_op_e;

   typedef enum logic [2:0] {
      IMM_R = 3'd0,  // no immediate
      IMM_I = 3'd1,
      IMM_S = 3'd2,
      IMM_B = 3'd3,
      IMM_U = 3'd4
   } imm_type_e;

   typedef enum logic [1:0] {
      CSR_NONE = 2'd0,
      CSR_W    = 2'd1,  // write
      CSR_S    = 2'd2,  // set bits
      CSR_C    = 2'd3   // clear bits
   } csr_wsc_e;

   typedef enum logic {
      ALUSRC_RS2 = 1'b0,
      ALUSRC_IMM = 1'b1
   } alu_src_e;

   // 20 bit decode control word, lui at the msb
   typedef struct packed {
      logic         lui;
      logic         auipc;
      logic         mret;
      logic         csr;       // csr access enable
      logic         csr_uimm;  // rs1 field used as uimm
      csr_wsc_e     csr_wsc;
      logic         memtoreg;
      logic         memwrite;
      branch_type_e branchtype;
      alu_src_e     alusrc;
      logic         regwrite;
      logic         jump;
      alu_op_e      aluop;
      imm_type_e    immtype;
   } maindec_ctrl_t;

   // flush / idle word: no side effects at all
   localparam maindec_ctrl_t CTRL_BUBBLE = '{
      lui:        1'b0,
      auipc:      1'b0,
      mret:       1'b0,
      csr:        1'b0,
      csr_uimm:   1'b0,
      csr_wsc:    CSR_NONE,
      memtoreg:   1'b0,
      memwrite:   1'b0,
      branchtype: BR_NONE,
      alusrc:     ALUSRC_RS2,
      regwrite:   1'b0,
      jump:       1'b0,
      aluop:      ALUOP_LWSWJALR,
      immtype:    IMM_R
   };

endpackage
